// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_masked_inv_mult -o sim_tb
	out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf obj_dir

// ==== project.f ====
verilog/sbox_mask_pkg.sv
verilog/masked_gf16_inv.sv
verilog/masked_gf16_mult.sv
verilog/pipe_stage_reg.sv
verilog/masked_inv_mult_stage.sv
verif/masked_inv_mult_props.sv
verif/tb_masked_inv_mult.sv

// ==== verif/masked_inv_mult_props.sv ====
`timescale 1ns/1ps

module masked_inv_mult_props (
	input logic                        clk,
	input logic                        arst_n,
	input logic                        in_valid,
	input logic                        in_ready,
	input logic                        out_valid,
	input logic                        out_ready,
	input sbox_mask_pkg::byte_shares_t out_data
);
	import sbox_mask_pkg::*;

	// nothing leaves the pipeline while reset is held
	a_no_valid_in_reset: assert property (
		@(posedge clk) !arst_n |-> !out_valid
	) else $error("out_valid high while arst_n is low");

	// stalled result keeps its shares
	a_data_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> $stable(out_data)
	) else $error("out_data changed while stalled");

	a_valid_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid
	) else $error("out_valid dropped before transfer");

	// an empty output only fills with an input taken two edges before
	a_result_has_input: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(out_valid) |-> $past(in_valid && in_ready, 2)
	) else $error("out_valid rose without an input accepted two cycles earlier");

endmodule

bind masked_inv_mult_stage masked_inv_mult_props u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data)
);

// ==== verif/tb_masked_inv_mult.sv ====
`timescale 1ns/1ps

module tb_masked_inv_mult;
	import sbox_mask_pkg::*;

	localparam int n_vec = 20;
	localparam int n_pass = 2;
	localparam int wd_cycles = n_vec * n_pass * 20 + 200;
	localparam logic [15:0] lfsr_seed = 16'd52423;

	// each entry is {data byte, element}
	// elements 0..15, a zero element with nonzero data, one input repeated
	localparam logic [11:0] stim [n_vec] = '{
		12'h000, 12'hFF0, 12'h5A1, 12'h122, 12'h343, 12'h564, 12'h785, 12'h9A6,
		12'hBC7, 12'hDE8, 12'hF09, 12'h11A, 12'h2EB, 12'hC3C, 12'h87D, 12'h69E,
		12'hA5F, 12'hA5F, 12'hA5F, 12'h3B0
	};

	typedef struct packed {
		logic [7:0] data;
		gf16_t      elem;
		logic [7:0] result;
	} vec_t;

	logic         clk;
	logic         arst_n;
	logic         in_valid;
	logic         in_ready;
	byte_shares_t in_data;
	gf16_shares_t in_elem;
	rand_t        in_rand;
	logic         out_valid;
	logic         out_ready;
	byte_shares_t out_data;

	vec_t        vectors [n_vec];
	logic [15:0] lfsr_state;
	logic [7:0]  cur_result;
	logic        random_ready;
	logic        fixed_latency;
	logic [7:0]  exp_q [$];
	int          acc_q [$];
	logic [7:0]  sb_value;
	int          sb_cycle;
	int          cyc;
	int          n_out;
	int          n_checks;
	int          val_errors;
	int          proto_errors;

	masked_inv_mult_stage DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.in_elem   (in_elem),
		.in_rand   (in_rand),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	always #2 clk = ~clk;

	// field product by shift and add, x^4 folds back to x+1
	function automatic gf16_t ref_mul(input gf16_t x, input gf16_t y);
		gf16_t acc;
		gf16_t sh;
		acc = '0;
		sh = x;
		for (int i = 0; i < 4; i++) begin
			if (y[i])
				acc = acc ^ sh;
			sh = sh[3] ? ({sh[2:0], 1'b0} ^ 4'b0011) : {sh[2:0], 1'b0};
		end
		return acc;
	endfunction

	// search for the element whose product is one, zero stays zero
	function automatic gf16_t ref_inv(input gf16_t x);
		gf16_t y;
		y = '0;
		for (int c = 1; c < 16; c++) begin
			if (ref_mul(x, gf16_t'(c)) == 4'h1)
				y = gf16_t'(c);
		end
		return y;
	endfunction

	function automatic logic [7:0] expected_byte(input logic [7:0] d, input gf16_t e);
		gf16_t e_inv;
		e_inv = ref_inv(e);
		return {ref_mul(d[7:4], e_inv), ref_mul(d[3:0], e_inv)};
	endfunction

	// x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	task automatic check_byte(input byte_shares_t got, input logic [7:0] want);
		logic [7:0] value;
		value = got.share0 ^ got.share1;
		n_checks++;
		if (value !== want) begin
			val_errors++;
			$display("Error %0t ns: out_data recombines to %h, expected %h",
				$time, value, want);
		end
	endtask

	task automatic check_ready(input logic got, input logic want, input string what);
		n_checks++;
		if (got !== want) begin
			proto_errors++;
			$display("Error %0t ns: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_latency(input int got, input int want);
		n_checks++;
		if (got != want) begin
			proto_errors++;
			$display("Error %0t ns: result took %0d cycles, expected %0d",
				$time, got, want);
		end
	endtask

	// advance to just after the next rising edge
	task automatic cycle_step();
		logic [31:0] bits;
		@(posedge clk);
		#0.5;
		if (random_ready) begin
			draw_bits(1, bits);
			out_ready = bits[0];
		end
	endtask

	task automatic send_vector(input int idx);
		logic [31:0] bits;
		logic [7:0]  d0;
		gf16_t       e0;
		logic        taken;
		draw_bits(8, bits);
		d0 = bits[7:0];
		draw_bits(4, bits);
		e0 = bits[3:0];
		draw_bits(rand_w, bits);
		in_valid = 1'b1;
		in_data.share0 = d0;
		in_data.share1 = d0 ^ vectors[idx].data;
		in_elem.share0 = e0;
		in_elem.share1 = e0 ^ vectors[idx].elem;
		in_rand = bits[rand_w-1:0];
		cur_result = vectors[idx].result;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			cycle_step();
		end
	endtask

	task automatic drain();
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			cycle_step();
	endtask

	// handshakes are stable half a cycle after the drive point
	always @(negedge clk) begin
		cyc++;
		if (arst_n) begin
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					proto_errors++;
					$display("out_valid delivered a result with no input waiting at %0t ns",
						$time);
				end else begin
					sb_value = exp_q.pop_front();
					sb_cycle = acc_q.pop_front();
					check_byte(out_data, sb_value);
					if (fixed_latency)
						check_latency(cyc - sb_cycle, 2);
					n_out++;
				end
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(cur_result);
				acc_q.push_back(cyc);
			end
			if (fixed_latency && in_valid)
				check_ready(in_ready, 1'b1, "in_ready");
		end
	end

	initial begin
		#(wd_cycles * 4);
		$display("run timed out after %0d cycles with results still missing", wd_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		in_elem = '0;
		in_rand = '0;
		out_ready = 1'b1;
		lfsr_state = lfsr_seed;
		cur_result = '0;
		random_ready = 1'b0;
		fixed_latency = 1'b0;
		cyc = 0;
		n_out = 0;
		n_checks = 0;
		val_errors = 0;
		proto_errors = 0;
		for (int i = 0; i < n_vec; i++) begin
			vectors[i].data = stim[i][11:4];
			vectors[i].elem = stim[i][3:0];
			vectors[i].result = expected_byte(stim[i][11:4], stim[i][3:0]);
		end

		repeat (10) @(posedge clk);
		#0.5;
		arst_n = 1'b1;
		@(negedge clk);
		check_ready(out_valid, 1'b0, "out_valid after reset");
		check_ready(in_ready, 1'b1, "in_ready after reset");
		cycle_step();

		// back to back with the sink always ready
		fixed_latency = 1'b1;
		for (int i = 0; i < n_vec; i++)
			send_vector(i);
		drain();
		fixed_latency = 1'b0;

		// sink stalls at random
		random_ready = 1'b1;
		for (int i = 0; i < n_vec; i++)
			send_vector(i);
		drain();
		random_ready = 1'b0;
		out_ready = 1'b1;
		repeat (4) cycle_step();

		if (n_out != n_vec * n_pass) begin
			proto_errors++;
			$display("received %0d results but sent %0d inputs", n_out, n_vec * n_pass);
		end
		$display("Summary: %0d value errors, %0d handshake errors, %0d checks",
			val_errors, proto_errors, n_checks);
		if (val_errors == 0 && proto_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verilog/masked_gf16_inv.sv ====
`timescale 1ns/1ps

module masked_gf16_inv (
	input  sbox_mask_pkg::gf16_shares_t          elem,
	input  logic [sbox_mask_pkg::inv_rand_w-1:0] rand_bits,
	output sbox_mask_pkg::gf16_shares_t          inv
);
	import sbox_mask_pkg::*;

	// the inverse x^14 has algebraic degree three, its ANF over the
	// polynomial coordinates a3..a0 is
	//   b0 = a0^a1^a2^a3 ^ a0a2^a1a2 ^ a0a1a2^a1a2a3
	//   b1 = a3 ^ a0a1^a0a2^a1a2^a1a3 ^ a0a1a3
	//   b2 = a2^a3 ^ a0a1^a0a2^a0a3 ^ a0a2a3
	//   b3 = a1^a2^a3 ^ a0a3^a1a3^a2a3 ^ a1a2a3
	// zero maps to zero since no constant term is present

	// shared AND of two bits, bit 0 of each operand is domain 0
	function automatic logic [1:0] dom_and2(
		input logic [1:0] x,
		input logic [1:0] y,
		input logic       r
	);
		logic s0;
		logic s1;
		s0 = (x[0] & y[0]) ^ (x[0] & y[1]) ^ r;
		s1 = (x[1] & y[1]) ^ (x[1] & y[0]) ^ r;
		return {s1, s0};
	endfunction

	// shared AND of three bits
	// each domain keeps the terms where it owns at least two factors
	function automatic logic [1:0] dom_and3(
		input logic [1:0] x,
		input logic [1:0] y,
		input logic [1:0] z,
		input logic       r
	);
		logic s0;
		logic s1;
		s0 = (x[0] & y[0] & z[0]) ^ (x[0] & y[0] & z[1]) ^
			(x[0] & y[1] & z[0]) ^ (x[1] & y[0] & z[0]) ^ r;
		s1 = (x[1] & y[1] & z[1]) ^ (x[1] & y[1] & z[0]) ^
			(x[1] & y[0] & z[1]) ^ (x[0] & y[1] & z[1]) ^ r;
		return {s1, s0};
	endfunction

	// per-coordinate share pairs
	logic [1:0] a [gf16_w];
	logic [1:0] lin [gf16_w];

	// degree-two monomials
	logic [1:0] p01;
	logic [1:0] p02;
	logic [1:0] p03;
	logic [1:0] p12;
	logic [1:0] p13;
	logic [1:0] p23;

	// degree-three monomials
	logic [1:0] t012;
	logic [1:0] t013;
	logic [1:0] t023;
	logic [1:0] t123;

	logic [gf16_w-1:0] out_sh [2];

	for (genvar k = 0; k < gf16_w; k++) begin : g_coord
		assign a[k] = {elem.share1[k], elem.share0[k]};
		// linear terms get a fresh mask in both domains
		assign lin[k] = a[k] ^ {2{rand_bits[k]}};
	end

	// rand_bits[9:4] mask the cross terms of the pairs
	assign p01 = dom_and2(a[0], a[1], rand_bits[4]);
	assign p02 = dom_and2(a[0], a[2], rand_bits[5]);
	assign p03 = dom_and2(a[0], a[3], rand_bits[6]);
	assign p12 = dom_and2(a[1], a[2], rand_bits[7]);
	assign p13 = dom_and2(a[1], a[3], rand_bits[8]);
	assign p23 = dom_and2(a[2], a[3], rand_bits[9]);

	// rand_bits[13:10] mask the cross terms of the triples
	assign t012 = dom_and3(a[0], a[1], a[2], rand_bits[10]);
	assign t013 = dom_and3(a[0], a[1], a[3], rand_bits[11]);
	assign t023 = dom_and3(a[0], a[2], a[3], rand_bits[12]);
	assign t123 = dom_and3(a[1], a[2], a[3], rand_bits[13]);

	// each domain sums its own monomial shares, masks cancel on recombination
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			out_sh[s][0] = lin[0][s] ^ lin[1][s] ^ lin[2][s] ^ lin[3][s] ^
				p02[s] ^ p12[s] ^ t012[s] ^ t123[s];
			out_sh[s][1] = lin[3][s] ^ p01[s] ^ p02[s] ^ p12[s] ^ p13[s] ^
				t013[s];
			out_sh[s][2] = lin[2][s] ^ lin[3][s] ^ p01[s] ^ p02[s] ^ p03[s] ^
				t023[s];
			out_sh[s][3] = lin[1][s] ^ lin[2][s] ^ lin[3][s] ^ p03[s] ^ p13[s] ^
				p23[s] ^ t123[s];
		end
	end

	assign inv.share0 = out_sh[0];
	assign inv.share1 = out_sh[1];

endmodule

// ==== verilog/masked_gf16_mult.sv ====
`timescale 1ns/1ps

module masked_gf16_mult (
	input  sbox_mask_pkg::gf16_shares_t           a,
	input  sbox_mask_pkg::gf16_shares_t           b,
	input  logic [sbox_mask_pkg::mult_rand_w-1:0] rand_bits,
	output sbox_mask_pkg::gf16_shares_t           p
);
	import sbox_mask_pkg::*;

	// unmasked field product, polynomial basis modulo x^4+x+1
	function automatic gf16_t gf16_mul(
		input gf16_t x,
		input gf16_t y
	);
		logic [2*gf16_w-2:0] d;
		gf16_t               r;
		d = '0;
		for (int i = 0; i < gf16_w; i++) begin
			for (int j = 0; j < gf16_w; j++) begin
				d[i+j] = d[i+j] ^ (x[i] & y[j]);
			end
		end
		// fold x^4 = x+1, x^5 = x^2+x, x^6 = x^3+x^2
		r[0] = d[0] ^ d[4];
		r[1] = d[1] ^ d[4] ^ d[5];
		r[2] = d[2] ^ d[5] ^ d[6];
		r[3] = d[3] ^ d[6];
		return r;
	endfunction

	// inner-domain partial products
	gf16_t inner0;
	gf16_t inner1;

	// cross-domain partial products, already refreshed
	gf16_t cross01;
	gf16_t cross10;

	assign inner0 = gf16_mul(a.share0, b.share0);
	assign inner1 = gf16_mul(a.share1, b.share1);

	// the same mask enters both domains so the sum is unchanged
	assign cross01 = gf16_mul(a.share0, b.share1) ^ rand_bits;
	assign cross10 = gf16_mul(a.share1, b.share0) ^ rand_bits;

	assign p.share0 = inner0 ^ cross01;
	assign p.share1 = inner1 ^ cross10;

endmodule

// ==== verilog/masked_inv_mult_stage.sv ====
`timescale 1ns/1ps

module masked_inv_mult_stage (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  sbox_mask_pkg::byte_shares_t in_data,
	input  sbox_mask_pkg::gf16_shares_t in_elem,
	input  sbox_mask_pkg::rand_t        in_rand,
	output logic                        out_valid,
	input  logic                        out_ready,
	output sbox_mask_pkg::byte_shares_t out_data
);
	import sbox_mask_pkg::*;

	gf16_shares_t elem_inv;
	inv_stage_t   stage_d;
	inv_stage_t   stage_q;
	logic         mid_valid;
	logic         mid_ready;
	gf16_shares_t nib_hi;
	gf16_shares_t nib_lo;
	gf16_shares_t prod_hi;
	gf16_shares_t prod_lo;
	byte_shares_t prod;

	masked_gf16_inv u_inv (
		.elem      (in_elem),
		.rand_bits (in_rand[rand_inv_lsb +: inv_rand_w]),
		.inv       (elem_inv)
	);

	// multiplier randomness rides along with its data
	assign stage_d.data      = in_data;
	assign stage_d.inv       = elem_inv;
	assign stage_d.mult_rand = {in_rand[rand_hi_lsb +: mult_rand_w],
		in_rand[rand_lo_lsb +: mult_rand_w]};

	pipe_stage_reg #(
		.payload_t (inv_stage_t)
	) u_inv_reg (
		.clk      (clk),
		.arst_n   (arst_n),
		.up_valid (in_valid),
		.up_ready (in_ready),
		.up_data  (stage_d),
		.dn_valid (mid_valid),
		.dn_ready (mid_ready),
		.dn_data  (stage_q)
	);

	assign nib_hi.share0 = stage_q.data.share0[gf16_w +: gf16_w];
	assign nib_hi.share1 = stage_q.data.share1[gf16_w +: gf16_w];
	assign nib_lo.share0 = stage_q.data.share0[0 +: gf16_w];
	assign nib_lo.share1 = stage_q.data.share1[0 +: gf16_w];

	masked_gf16_mult u_mult_hi (
		.a         (nib_hi),
		.b         (stage_q.inv),
		.rand_bits (stage_q.mult_rand[mult_rand_w +: mult_rand_w]),
		.p         (prod_hi)
	);

	masked_gf16_mult u_mult_lo (
		.a         (nib_lo),
		.b         (stage_q.inv),
		.rand_bits (stage_q.mult_rand[0 +: mult_rand_w]),
		.p         (prod_lo)
	);

	assign prod.share0 = {prod_hi.share0, prod_lo.share0};
	assign prod.share1 = {prod_hi.share1, prod_lo.share1};

	pipe_stage_reg #(
		.payload_t (byte_shares_t)
	) u_out_reg (
		.clk      (clk),
		.arst_n   (arst_n),
		.up_valid (mid_valid),
		.up_ready (mid_ready),
		.up_data  (prod),
		.dn_valid (out_valid),
		.dn_ready (out_ready),
		.dn_data  (out_data)
	);

endmodule

// ==== verilog/pipe_stage_reg.sv ====
`timescale 1ns/1ps

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     up_valid,
	output logic     up_ready,
	input  payload_t up_data,
	output logic     dn_valid,
	input  logic     dn_ready,
	output payload_t dn_data
);

	logic     valid_q;
	payload_t data_q;

	// accept when empty or when the held item leaves this cycle
	assign up_ready = !valid_q || dn_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (up_ready) begin
			valid_q <= up_valid;
		end
	end

	// payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (up_valid && up_ready) begin
			data_q <= up_data;
		end
	end

	assign dn_valid = valid_q;
	assign dn_data  = data_q;

endmodule

// ==== verilog/sbox_mask_pkg.sv ====
package sbox_mask_pkg;

	// field element width, polynomial basis modulo x^4+x+1
	localparam int gf16_w = 4;

	// fresh randomness per transfer
	localparam int rand_w = 22;

	// randomness used by the shared inversion
	// 4 bits refresh the linear terms, 6 bits the degree-two terms,
	// 4 bits the degree-three terms
	localparam int inv_rand_w = 14;

	// randomness used by one shared multiplication, one bit per product bit
	localparam int mult_rand_w = 4;

	// slice positions inside the randomness word
	localparam int rand_inv_lsb = 0;
	localparam int rand_lo_lsb  = rand_inv_lsb + inv_rand_w;
	localparam int rand_hi_lsb  = rand_lo_lsb + mult_rand_w;

	typedef logic [gf16_w-1:0] gf16_t;

	// two Boolean shares of one field element
	typedef struct packed {
		gf16_t share0;
		gf16_t share1;
	} gf16_shares_t;

	// two Boolean shares of a byte
	// upper nibble and lower nibble are separate field elements
	typedef struct packed {
		logic [2*gf16_w-1:0] share0;
		logic [2*gf16_w-1:0] share1;
	} byte_shares_t;

	typedef logic [rand_w-1:0] rand_t;

	// payload of the first pipeline register
	// mult_rand carries the multiplier slices alongside their data,
	// upper half for the high nibble, lower half for the low nibble
	typedef struct packed {
		byte_shares_t              data;
		gf16_shares_t              inv;
		logic [2*mult_rand_w-1:0]  mult_rand;
	} inv_stage_t;

endpackage
